// File: include/rocc_dma_consts.svh
// constants for the custom-instruction memory copy accelerator
`ifndef ROCC_DMA_CONSTS_SVH
`define ROCC_DMA_CONSTS_SVH

// custom-0 major opcode
`define ROCC_OPCODE 7'h0b

// funct codes of the kept commands
`define FUNCT_CONFIG 7'd0
`define FUNCT_LOAD 7'd1
`define FUNCT_STATUS 7'd2
`define FUNCT_STORE 7'd3

// burst lengths in words
`define BURST_SHORT 128
`define BURST_LONG 1024

// local buffer holds one long burst
`define BUF_DEPTH 1024

// byte increment between consecutive words
`define WORD_STEP 4

// last tag value before rolling back to zero
`define TAG_WRAP 63

// memory command encodings
`define MEM_CMD_READ 5'd0
`define MEM_CMD_WRITE 5'd1

`endif

// File: src/rocc_dma_pkg.sv
// shared types of the memory copy accelerator
package rocc_dma_pkg;

  // register operand and response data
  typedef logic [31:0] xlen_t;

  // memory address
  typedef logic [31:0] addr_t;

  // memory data word
  typedef logic [31:0] word_t;

  // memory request tag
  typedef logic [8:0] tag_t;

  // memory command
  typedef logic [4:0] mem_cmd_t;

  // destination register index
  typedef logic [4:0] reg_idx_t;

  // instruction funct field
  typedef logic [6:0] funct_t;

  // buffer index, also used as word counter
  typedef logic [9:0] buf_idx_t;

  // burst sequencer states
  typedef enum logic [1:0] {
    BURST_IDLE,
    BURST_LOAD,
    BURST_STORE_PREP,
    BURST_STORE
  } burst_state_t;

endpackage

// File: src/rocc_cmd_decode.sv
// command decoder that accepts instructions, keeps the length flag and issues burst requests
`include "rocc_dma_consts.svh"

module rocc_cmd_decode (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   cmd_valid,
  input  logic [6:0]             cmd_opcode,
  input  rocc_dma_pkg::funct_t   cmd_funct,
  input  rocc_dma_pkg::reg_idx_t cmd_rd,
  input  logic                   cmd_xd,
  input  rocc_dma_pkg::xlen_t    cmd_rs1,
  input  rocc_dma_pkg::xlen_t    cmd_rs2,
  input  logic                   resp_pending,
  input  logic                   busy,
  output logic                   cmd_ready,
  output logic                   start_load,
  output logic                   start_store,
  output rocc_dma_pkg::addr_t    base_addr,
  output logic                   long_burst,
  output logic                   resp_req,
  output rocc_dma_pkg::funct_t   resp_funct,
  output rocc_dma_pkg::reg_idx_t resp_rd
);

  logic accept;
  logic is_custom;
  logic is_load;
  logic is_store;
  logic is_config;

  // one response in flight at a time
  assign cmd_ready = !resp_pending;
  assign accept    = cmd_valid && cmd_ready;

  assign is_custom = (cmd_opcode == `ROCC_OPCODE);
  assign is_config = is_custom && (cmd_funct == `FUNCT_CONFIG);
  assign is_load   = is_custom && (cmd_funct == `FUNCT_LOAD);
  assign is_store  = is_custom && (cmd_funct == `FUNCT_STORE);

  // rs2 has no meaning for any of the kept commands

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      start_load  <= 1'b0;
      start_store <= 1'b0;
      resp_req    <= 1'b0;
      long_burst  <= 1'b0;
    end
    else
    begin
      // burst commands during an active burst are dropped
      start_load  <= accept && is_load && !busy;
      start_store <= accept && is_store && !busy;
      resp_req    <= accept && cmd_xd;
      if (accept && is_config)
      begin
        long_burst <= cmd_rs1[0];
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      base_addr <= rocc_dma_pkg::addr_t'(cmd_rs1);
      resp_rd   <= cmd_rd;
      // foreign opcodes map to an unused funct, answered with zero
      if (is_custom)
      begin
        resp_funct <= cmd_funct;
      end
      else
      begin
        resp_funct <= '1;
      end
    end
  end

endmodule

// File: src/rocc_burst_ctrl.sv
// burst sequencer for memory loads into the buffer and stores out of it
`include "rocc_dma_consts.svh"

module rocc_burst_ctrl (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start_load,
  input  logic                   start_store,
  input  rocc_dma_pkg::addr_t    base_addr,
  input  logic                   long_burst,
  input  logic                   mem_req_ready,
  input  logic                   mem_resp_valid,
  input  rocc_dma_pkg::word_t    buf_rdata,
  output logic                   busy,
  output logic                   mem_req_valid,
  output rocc_dma_pkg::addr_t    mem_req_addr,
  output rocc_dma_pkg::tag_t     mem_req_tag,
  output rocc_dma_pkg::mem_cmd_t mem_req_cmd,
  output rocc_dma_pkg::word_t    mem_req_data,
  output logic                   buf_we,
  output logic                   buf_re,
  output rocc_dma_pkg::buf_idx_t buf_idx,
  output logic                   interrupt
);

  rocc_dma_pkg::burst_state_t state;
  rocc_dma_pkg::buf_idx_t     req_cnt;
  rocc_dma_pkg::buf_idx_t     resp_cnt;
  rocc_dma_pkg::buf_idx_t     last_idx;
  rocc_dma_pkg::tag_t         next_tag;
  logic                       req_fire;
  logic                       resp_take;

  assign req_fire  = mem_req_valid && mem_req_ready;
  assign resp_take = (state == rocc_dma_pkg::BURST_LOAD) && mem_resp_valid;

  assign next_tag = (mem_req_tag == rocc_dma_pkg::tag_t'(`TAG_WRAP)) ? '0 :
                    mem_req_tag + 1'b1;

  // strobe cycle already counts as busy
  assign busy = (state != rocc_dma_pkg::BURST_IDLE) || start_load || start_store;

  // store data comes straight from the buffer output register
  assign mem_req_data = buf_rdata;

  assign buf_we = resp_take;
  assign buf_re = (state == rocc_dma_pkg::BURST_STORE_PREP) ||
                  ((state == rocc_dma_pkg::BURST_STORE) && req_fire);

  always_comb
  begin
    case (state)
      rocc_dma_pkg::BURST_LOAD:  buf_idx = resp_cnt;
      // fetch the word after the one being accepted
      rocc_dma_pkg::BURST_STORE: buf_idx = req_cnt + 1'b1;
      default:                   buf_idx = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state         <= rocc_dma_pkg::BURST_IDLE;
      req_cnt       <= '0;
      resp_cnt      <= '0;
      last_idx      <= '0;
      mem_req_valid <= 1'b0;
      mem_req_addr  <= '0;
      mem_req_tag   <= '0;
      mem_req_cmd   <= `MEM_CMD_READ;
      interrupt     <= 1'b0;
    end
    else
    begin
      interrupt <= 1'b0;
      case (state)
        rocc_dma_pkg::BURST_IDLE:
        begin
          if (start_load || start_store)
          begin
            last_idx     <= long_burst ? rocc_dma_pkg::buf_idx_t'(`BURST_LONG - 1) :
                                         rocc_dma_pkg::buf_idx_t'(`BURST_SHORT - 1);
            req_cnt      <= '0;
            resp_cnt     <= '0;
            mem_req_addr <= base_addr;
            mem_req_tag  <= next_tag;
          end
          if (start_load)
          begin
            state         <= rocc_dma_pkg::BURST_LOAD;
            mem_req_cmd   <= `MEM_CMD_READ;
            mem_req_valid <= 1'b1;
          end
          else if (start_store)
          begin
            state       <= rocc_dma_pkg::BURST_STORE_PREP;
            mem_req_cmd <= `MEM_CMD_WRITE;
          end
        end
        rocc_dma_pkg::BURST_LOAD:
        begin
          if (req_fire)
          begin
            req_cnt      <= req_cnt + 1'b1;
            mem_req_addr <= mem_req_addr + rocc_dma_pkg::addr_t'(`WORD_STEP);
            if (req_cnt == last_idx)
            begin
              mem_req_valid <= 1'b0;
            end
          end
          // burst ends on the last response, not the last request
          if (resp_take)
          begin
            resp_cnt <= resp_cnt + 1'b1;
            if (resp_cnt == last_idx)
            begin
              state     <= rocc_dma_pkg::BURST_IDLE;
              interrupt <= 1'b1;
            end
          end
        end
        rocc_dma_pkg::BURST_STORE_PREP:
        begin
          // word 0 is in the buffer output register now
          state         <= rocc_dma_pkg::BURST_STORE;
          mem_req_valid <= 1'b1;
        end
        rocc_dma_pkg::BURST_STORE:
        begin
          if (req_fire)
          begin
            req_cnt      <= req_cnt + 1'b1;
            mem_req_addr <= mem_req_addr + rocc_dma_pkg::addr_t'(`WORD_STEP);
            if (req_cnt == last_idx)
            begin
              mem_req_valid <= 1'b0;
              state         <= rocc_dma_pkg::BURST_IDLE;
              interrupt     <= 1'b1;
            end
          end
        end
        default:
        begin
          state <= rocc_dma_pkg::BURST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: src/rocc_word_buffer.sv
// single-port word buffer with a registered read port
`include "rocc_dma_consts.svh"

module rocc_word_buffer (
  input  logic                   clock,
  input  logic                   we,
  input  logic                   re,
  input  rocc_dma_pkg::buf_idx_t idx,
  input  rocc_dma_pkg::word_t    wdata,
  output rocc_dma_pkg::word_t    rdata
);

  rocc_dma_pkg::word_t mem [`BUF_DEPTH];

  always_ff @(posedge clock)
  begin
    if (we)
    begin
      mem[idx] <= wdata;
    end
  end

  // output holds between reads, so store data survives a stalled request
  always_ff @(posedge clock)
  begin
    if (re)
    begin
      rdata <= mem[idx];
    end
  end

endmodule

// File: src/rocc_resp_unit.sv
// response stage that captures the reply data and holds it until the core takes it
`include "rocc_dma_consts.svh"

module rocc_resp_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   resp_req,
  input  rocc_dma_pkg::funct_t   resp_funct,
  input  rocc_dma_pkg::reg_idx_t resp_rd,
  input  logic                   busy,
  input  logic                   long_burst,
  input  logic                   resp_ready,
  output logic                   resp_valid,
  output rocc_dma_pkg::reg_idx_t resp_rd_out,
  output rocc_dma_pkg::xlen_t    resp_data,
  output logic                   resp_pending
);

  rocc_dma_pkg::xlen_t data_next;

  // a request still in the decoder register also counts as pending
  assign resp_pending = resp_valid || resp_req;

  always_comb
  begin
    case (resp_funct)
      `FUNCT_CONFIG: data_next = rocc_dma_pkg::xlen_t'(resp_rd);
      `FUNCT_LOAD:   data_next = rocc_dma_pkg::xlen_t'(busy);
      `FUNCT_STORE:  data_next = rocc_dma_pkg::xlen_t'(busy);
      `FUNCT_STATUS: data_next = rocc_dma_pkg::xlen_t'({long_burst, busy});
      default:       data_next = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      resp_valid <= 1'b0;
    end
    else if (resp_req)
    begin
      resp_valid <= 1'b1;
    end
    else if (resp_valid && resp_ready)
    begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock)
  begin
    if (resp_req)
    begin
      resp_rd_out <= resp_rd;
      resp_data   <= data_next;
    end
  end

endmodule

// File: src/rocc_dma_top.sv
// top level of the memory copy accelerator joining decoder, sequencer, buffer and responder
module rocc_dma_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  rocc_dma_pkg::funct_t   cmd_funct,
  input  logic [6:0]             cmd_opcode,
  input  rocc_dma_pkg::reg_idx_t cmd_rd,
  input  logic                   cmd_xd,
  input  rocc_dma_pkg::xlen_t    cmd_rs1,
  input  rocc_dma_pkg::xlen_t    cmd_rs2,
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output rocc_dma_pkg::reg_idx_t resp_rd,
  output rocc_dma_pkg::xlen_t    resp_data,
  output logic                   mem_req_valid,
  input  logic                   mem_req_ready,
  output rocc_dma_pkg::addr_t    mem_req_addr,
  output rocc_dma_pkg::tag_t     mem_req_tag,
  output rocc_dma_pkg::mem_cmd_t mem_req_cmd,
  output rocc_dma_pkg::word_t    mem_req_data,
  output logic [1:0]             mem_req_size,
  output logic [3:0]             mem_req_mask,
  input  logic                   mem_resp_valid,
  input  rocc_dma_pkg::word_t    mem_resp_data,
  output logic                   interrupt
);

  logic                   start_load;
  logic                   start_store;
  logic                   long_burst;
  logic                   busy;
  logic                   resp_req;
  logic                   resp_pending;
  rocc_dma_pkg::addr_t    base_addr;
  rocc_dma_pkg::funct_t   dec_resp_funct;
  rocc_dma_pkg::reg_idx_t dec_resp_rd;
  logic                   buf_we;
  logic                   buf_re;
  rocc_dma_pkg::buf_idx_t buf_idx;
  rocc_dma_pkg::word_t    buf_rdata;

  // every access is a full 32-bit word
  assign mem_req_size = 2'd2;
  assign mem_req_mask = 4'hf;

  rocc_cmd_decode u_decode (
    .clock        (clock),
    .reset        (reset),
    .cmd_valid    (cmd_valid),
    .cmd_opcode   (cmd_opcode),
    .cmd_funct    (cmd_funct),
    .cmd_rd       (cmd_rd),
    .cmd_xd       (cmd_xd),
    .cmd_rs1      (cmd_rs1),
    .cmd_rs2      (cmd_rs2),
    .resp_pending (resp_pending),
    .busy         (busy),
    .cmd_ready    (cmd_ready),
    .start_load   (start_load),
    .start_store  (start_store),
    .base_addr    (base_addr),
    .long_burst   (long_burst),
    .resp_req     (resp_req),
    .resp_funct   (dec_resp_funct),
    .resp_rd      (dec_resp_rd)
  );

  rocc_burst_ctrl u_burst (
    .clock          (clock),
    .reset          (reset),
    .start_load     (start_load),
    .start_store    (start_store),
    .base_addr      (base_addr),
    .long_burst     (long_burst),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .buf_rdata      (buf_rdata),
    .busy           (busy),
    .mem_req_valid  (mem_req_valid),
    .mem_req_addr   (mem_req_addr),
    .mem_req_tag    (mem_req_tag),
    .mem_req_cmd    (mem_req_cmd),
    .mem_req_data   (mem_req_data),
    .buf_we         (buf_we),
    .buf_re         (buf_re),
    .buf_idx        (buf_idx),
    .interrupt      (interrupt)
  );

  // load responses are written without further buffering
  rocc_word_buffer u_buffer (
    .clock (clock),
    .we    (buf_we),
    .re    (buf_re),
    .idx   (buf_idx),
    .wdata (mem_resp_data),
    .rdata (buf_rdata)
  );

  rocc_resp_unit u_resp (
    .clock        (clock),
    .reset        (reset),
    .resp_req     (resp_req),
    .resp_funct   (dec_resp_funct),
    .resp_rd      (dec_resp_rd),
    .busy         (busy),
    .long_burst   (long_burst),
    .resp_ready   (resp_ready),
    .resp_valid   (resp_valid),
    .resp_rd_out  (resp_rd),
    .resp_data    (resp_data),
    .resp_pending (resp_pending)
  );

endmodule

// File: testbench/rocc_dma_properties.sv
// handshake and interrupt properties of the memory copy accelerator
module rocc_dma_properties (
  input logic                   clock,
  input logic                   reset,
  input logic                   mem_req_valid,
  input logic                   mem_req_ready,
  input rocc_dma_pkg::addr_t    mem_req_addr,
  input rocc_dma_pkg::tag_t     mem_req_tag,
  input rocc_dma_pkg::mem_cmd_t mem_req_cmd,
  input rocc_dma_pkg::word_t    mem_req_data,
  input logic                   resp_valid,
  input logic                   resp_ready,
  input rocc_dma_pkg::reg_idx_t resp_rd,
  input rocc_dma_pkg::xlen_t    resp_data,
  input logic                   interrupt
);
  timeunit 1ns;
  timeprecision 1ps;

  // a stalled memory request keeps all of its fields
  property req_held_under_stall;
    @(posedge clock) disable iff (reset)
      (mem_req_valid && !mem_req_ready) |=>
        (mem_req_valid && $stable(mem_req_addr) && $stable(mem_req_tag) &&
         $stable(mem_req_cmd) && $stable(mem_req_data));
  endproperty

  // response stays up until the core takes it
  property resp_held_until_taken;
    @(posedge clock) disable iff (reset)
      (resp_valid && !resp_ready) |=>
        (resp_valid && $stable(resp_rd) && $stable(resp_data));
  endproperty

  property interrupt_single_cycle;
    @(posedge clock) disable iff (reset)
      interrupt |=> !interrupt;
  endproperty

  assert property (req_held_under_stall)
    else $error("memory request changed while stalled");
  assert property (resp_held_until_taken)
    else $error("response dropped or changed before it was taken");
  assert property (interrupt_single_cycle)
    else $error("interrupt high for more than one cycle");

endmodule

// File: testbench/rocc_dma_tb.sv
// testbench for the memory copy accelerator with memory model and reference checks
`include "rocc_dma_consts.svh"

module rocc_dma_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // words moved over all bursts, eight cycles each plus slack
  localparam int TOTAL_WORDS     = 5 * `BURST_SHORT + 2 * `BURST_LONG;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 8 + 2000;

  logic                   clock;
  logic                   reset;
  logic                   cmd_valid;
  logic                   cmd_ready;
  rocc_dma_pkg::funct_t   cmd_funct;
  logic [6:0]             cmd_opcode;
  rocc_dma_pkg::reg_idx_t cmd_rd;
  logic                   cmd_xd;
  rocc_dma_pkg::xlen_t    cmd_rs1;
  rocc_dma_pkg::xlen_t    cmd_rs2;
  logic                   resp_valid;
  logic                   resp_ready;
  rocc_dma_pkg::reg_idx_t resp_rd;
  rocc_dma_pkg::xlen_t    resp_data;
  logic                   mem_req_valid;
  logic                   mem_req_ready;
  rocc_dma_pkg::addr_t    mem_req_addr;
  rocc_dma_pkg::tag_t     mem_req_tag;
  rocc_dma_pkg::mem_cmd_t mem_req_cmd;
  rocc_dma_pkg::word_t    mem_req_data;
  logic [1:0]             mem_req_size;
  logic [3:0]             mem_req_mask;
  logic                   mem_resp_valid;
  rocc_dma_pkg::word_t    mem_resp_data;
  logic                   interrupt;

  int                     mismatch_count = 0;
  int                     failure_count = 0;
  logic [31:0]            lcg_state = 32'd9213;
  rocc_dma_pkg::word_t    mem_written [rocc_dma_pkg::addr_t];
  logic [1:0]             rd_pipe_valid = 2'b00;
  rocc_dma_pkg::word_t    rd_pipe_data [2];
  rocc_dma_pkg::reg_idx_t resp_rd_q [$];
  rocc_dma_pkg::xlen_t    resp_data_q [$];
  logic                   burst_active = 1'b0;
  rocc_dma_pkg::addr_t    exp_base;
  rocc_dma_pkg::addr_t    exp_src;
  rocc_dma_pkg::tag_t     exp_tag = '0;
  rocc_dma_pkg::mem_cmd_t exp_cmd;
  int                     exp_len = 0;
  int                     burst_req_count = 0;
  int                     irq_count = 0;
  int                     burst_irq_start = 0;

  rocc_dma_top u_dut (
    .clock          (clock),
    .reset          (reset),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .cmd_funct      (cmd_funct),
    .cmd_opcode     (cmd_opcode),
    .cmd_rd         (cmd_rd),
    .cmd_xd         (cmd_xd),
    .cmd_rs1        (cmd_rs1),
    .cmd_rs2        (cmd_rs2),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_rd        (resp_rd),
    .resp_data      (resp_data),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_addr   (mem_req_addr),
    .mem_req_tag    (mem_req_tag),
    .mem_req_cmd    (mem_req_cmd),
    .mem_req_data   (mem_req_data),
    .mem_req_size   (mem_req_size),
    .mem_req_mask   (mem_req_mask),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data),
    .interrupt      (interrupt)
  );

  bind rocc_dma_top rocc_dma_properties u_props (
    .clock         (clock),
    .reset         (reset),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_addr  (mem_req_addr),
    .mem_req_tag   (mem_req_tag),
    .mem_req_cmd   (mem_req_cmd),
    .mem_req_data  (mem_req_data),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready),
    .resp_rd       (resp_rd),
    .resp_data     (resp_data),
    .interrupt     (interrupt)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // contents of memory that was never written
  function automatic rocc_dma_pkg::word_t mem_word(input rocc_dma_pkg::addr_t addr);
    return rocc_dma_pkg::word_t'(addr ^ 32'hA5A5_0000);
  endfunction

  function automatic rocc_dma_pkg::tag_t tag_after(input rocc_dma_pkg::tag_t tag);
    return (tag == rocc_dma_pkg::tag_t'(`TAG_WRAP)) ? '0 : tag + 1'b1;
  endfunction

  task automatic check_word(input string name, input rocc_dma_pkg::word_t actual,
                            input rocc_dma_pkg::word_t expected);
    if (actual !== expected)
    begin
      mismatch_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_xlen(input string name, input rocc_dma_pkg::xlen_t actual,
                            input rocc_dma_pkg::xlen_t expected);
    if (actual !== expected)
    begin
      mismatch_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_addr(input string name, input rocc_dma_pkg::addr_t actual,
                            input rocc_dma_pkg::addr_t expected);
    if (actual !== expected)
    begin
      mismatch_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_tag(input string name, input rocc_dma_pkg::tag_t actual,
                           input rocc_dma_pkg::tag_t expected);
    if (actual !== expected)
    begin
      mismatch_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_rd(input string name, input rocc_dma_pkg::reg_idx_t actual,
                          input rocc_dma_pkg::reg_idx_t expected);
    if (actual !== expected)
    begin
      mismatch_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_cmd(input string name, input rocc_dma_pkg::mem_cmd_t actual,
                           input rocc_dma_pkg::mem_cmd_t expected);
    if (actual !== expected)
    begin
      mismatch_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_size(input string name, input logic [1:0] actual,
                            input logic [1:0] expected);
    if (actual !== expected)
    begin
      mismatch_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_mask(input string name, input logic [3:0] actual,
                            input logic [3:0] expected);
    if (actual !== expected)
    begin
      mismatch_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      mismatch_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
  endtask

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // memory model, response sink and request checker, all on the falling edge
  always @(negedge clock)
  begin : bus_model
    rocc_dma_pkg::addr_t offset;
    lcg_state     = lcg_next(lcg_state);
    mem_req_ready = (lcg_state[17:16] != 2'b00);
    lcg_state     = lcg_next(lcg_state);
    resp_ready    = (lcg_state[17:16] != 2'b00);
    // read data comes back two cycles after its request
    mem_resp_valid   = rd_pipe_valid[1];
    mem_resp_data    = rd_pipe_data[1];
    rd_pipe_valid[1] = rd_pipe_valid[0];
    rd_pipe_data[1]  = rd_pipe_data[0];
    rd_pipe_valid[0] = 1'b0;
    if (interrupt)
    begin
      irq_count++;
    end
    if (resp_valid && resp_ready)
    begin
      resp_rd_q.push_back(resp_rd);
      resp_data_q.push_back(resp_data);
    end
    if (mem_req_valid && mem_req_ready)
    begin
      if (!burst_active || burst_req_count >= exp_len)
      begin
        failure_count++;
        $display("memory request to 0x%h arrived outside an expected burst", mem_req_addr);
      end
      else
      begin
        offset = rocc_dma_pkg::addr_t'(burst_req_count * `WORD_STEP);
        check_addr("mem_req_addr", mem_req_addr, exp_base + offset);
        check_tag("mem_req_tag", mem_req_tag, exp_tag);
        check_cmd("mem_req_cmd", mem_req_cmd, exp_cmd);
        // every access moves one full word
        check_size("mem_req_size", mem_req_size, 2'd2);
        check_mask("mem_req_mask", mem_req_mask, 4'hf);
        if (exp_cmd == `MEM_CMD_WRITE)
        begin
          check_word("mem_req_data", mem_req_data, mem_word(exp_src + offset));
        end
      end
      burst_req_count++;
      if (mem_req_cmd == `MEM_CMD_WRITE)
      begin
        mem_written[mem_req_addr] = mem_req_data;
      end
      else
      begin
        rd_pipe_valid[0] = 1'b1;
        rd_pipe_data[0]  = mem_written.exists(mem_req_addr) ? mem_written[mem_req_addr] :
                           mem_word(mem_req_addr);
      end
    end
  end

  task automatic send_cmd(input rocc_dma_pkg::funct_t funct, input rocc_dma_pkg::reg_idx_t rd,
                          input logic xd, input rocc_dma_pkg::xlen_t rs1);
    int waited;
    waited = 0;
    @(negedge clock);
    while (!cmd_ready && waited < 100)
    begin
      @(negedge clock);
      waited++;
    end
    if (!cmd_ready)
    begin
      failure_count++;
      $display("cmd_ready stayed low, command with funct %0d was never sent", funct);
    end
    else
    begin
      cmd_valid  = 1'b1;
      cmd_opcode = `ROCC_OPCODE;
      cmd_funct  = funct;
      cmd_rd     = rd;
      cmd_xd     = xd;
      cmd_rs1    = rs1;
      cmd_rs2    = '0;
      @(negedge clock);
      cmd_valid  = 1'b0;
    end
  endtask

  task automatic expect_resp(input rocc_dma_pkg::reg_idx_t rd, input rocc_dma_pkg::xlen_t data);
    int waited;
    waited = 0;
    while (resp_rd_q.size() == 0 && waited < 100)
    begin
      @(negedge clock);
      waited++;
    end
    if (resp_rd_q.size() == 0)
    begin
      failure_count++;
      $display("no response arrived for destination register %0d", rd);
    end
    else
    begin
      check_rd("resp_rd", resp_rd_q.pop_front(), rd);
      check_xlen("resp_data", resp_data_q.pop_front(), data);
    end
  endtask

  task automatic start_burst(input rocc_dma_pkg::funct_t funct, input rocc_dma_pkg::addr_t base,
                             input rocc_dma_pkg::addr_t src, input int len);
    exp_tag         = tag_after(exp_tag);
    exp_base        = base;
    exp_src         = src;
    exp_len         = len;
    exp_cmd         = (funct == `FUNCT_STORE) ? `MEM_CMD_WRITE : `MEM_CMD_READ;
    burst_req_count = 0;
    burst_irq_start = irq_count;
    burst_active    = 1'b1;
    send_cmd(funct, 5'd0, 1'b0, base);
  endtask

  task automatic finish_burst();
    int waited;
    waited = 0;
    while (irq_count == burst_irq_start && waited < exp_len * 8)
    begin
      @(negedge clock);
      waited++;
    end
    if (irq_count == burst_irq_start)
    begin
      failure_count++;
      $display("burst from 0x%h ended without an interrupt", exp_base);
    end
    repeat (4) @(negedge clock);
    check_xlen("request count", rocc_dma_pkg::xlen_t'(burst_req_count),
               rocc_dma_pkg::xlen_t'(exp_len));
    check_xlen("interrupt count", rocc_dma_pkg::xlen_t'(irq_count - burst_irq_start), 32'd1);
    burst_active = 1'b0;
  endtask

  task automatic verify_copy(input rocc_dma_pkg::addr_t src, input rocc_dma_pkg::addr_t dst,
                             input int len);
    rocc_dma_pkg::addr_t offset;
    int                  k;
    for (k = 0; k < len; k++)
    begin
      offset = rocc_dma_pkg::addr_t'(k * `WORD_STEP);
      if (!mem_written.exists(dst + offset))
      begin
        failure_count++;
        $display("no store reached address 0x%h", dst + offset);
      end
      else
      begin
        check_word("copied word", mem_written[dst + offset], mem_word(src + offset));
      end
    end
  endtask

  task automatic copy_block(input rocc_dma_pkg::addr_t src, input rocc_dma_pkg::addr_t dst,
                            input int len);
    start_burst(`FUNCT_LOAD, src, src, len);
    finish_burst();
    start_burst(`FUNCT_STORE, dst, src, len);
    finish_burst();
    verify_copy(src, dst, len);
  endtask

  initial
  begin
    reset          = 1'b1;
    cmd_valid      = 1'b0;
    cmd_funct      = '0;
    cmd_opcode     = '0;
    cmd_rd         = '0;
    cmd_xd         = 1'b0;
    cmd_rs1        = '0;
    cmd_rs2        = '0;
    resp_ready     = 1'b0;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    repeat (2) @(negedge clock);
    reset = 1'b0;

    check_flag("cmd_ready", cmd_ready, 1'b1);
    check_flag("resp_valid", resp_valid, 1'b0);
    check_flag("mem_req_valid", mem_req_valid, 1'b0);
    check_flag("interrupt", interrupt, 1'b0);
    check_tag("mem_req_tag", mem_req_tag, '0);

    // config echoes rd, status reports the length flag
    send_cmd(`FUNCT_CONFIG, 5'd7, 1'b1, 32'd0);
    expect_resp(5'd7, 32'd7);
    send_cmd(`FUNCT_STATUS, 5'd3, 1'b1, 32'd0);
    expect_resp(5'd3, 32'd0);
    send_cmd(`FUNCT_CONFIG, 5'd9, 1'b1, 32'd1);
    expect_resp(5'd9, 32'd9);
    send_cmd(`FUNCT_STATUS, 5'd3, 1'b1, 32'd0);
    expect_resp(5'd3, 32'd2);
    send_cmd(`FUNCT_CONFIG, 5'd1, 1'b1, 32'd0);
    expect_resp(5'd1, 32'd1);

    // short copies, tags 1 to 4
    copy_block(32'h0000_1000, 32'h0008_0000, `BURST_SHORT);
    copy_block(32'h0000_2000, 32'h0009_0000, `BURST_SHORT);

    // status and a second load while a burst runs
    start_burst(`FUNCT_LOAD, 32'h0000_3000, 32'h0000_3000, `BURST_SHORT);
    send_cmd(`FUNCT_STATUS, 5'd4, 1'b1, 32'd0);
    expect_resp(5'd4, 32'd1);
    send_cmd(`FUNCT_LOAD, 5'd5, 1'b1, 32'h0000_7000);
    expect_resp(5'd5, 32'd1);
    finish_burst();
    repeat (20) @(negedge clock);
    check_xlen("request count after idle", rocc_dma_pkg::xlen_t'(burst_req_count),
               rocc_dma_pkg::xlen_t'(`BURST_SHORT));

    // long copy under back-pressure
    send_cmd(`FUNCT_CONFIG, 5'd2, 1'b1, 32'd1);
    expect_resp(5'd2, 32'd2);
    copy_block(32'h0010_0000, 32'h0040_0000, `BURST_LONG);

    report_counts();
    if (mismatch_count == 0 && failure_count == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    failure_count++;
    $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    report_counts();
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: list.f
+incdir+include
src/rocc_dma_pkg.sv
src/rocc_cmd_decode.sv
src/rocc_burst_ctrl.sv
src/rocc_word_buffer.sv
src/rocc_resp_unit.sv
src/rocc_dma_top.sv
testbench/rocc_dma_properties.sv
testbench/rocc_dma_tb.sv

// File: Bender.yml
package:
  name: rocc_dma

sources:
  - include_dirs:
      - include
    files:
      - src/rocc_dma_pkg.sv
      - src/rocc_cmd_decode.sv
      - src/rocc_burst_ctrl.sv
      - src/rocc_word_buffer.sv
      - src/rocc_resp_unit.sv
      - src/rocc_dma_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/rocc_dma_properties.sv
      - testbench/rocc_dma_tb.sv
